/* verilog/core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

////////////////////
// Datapath

// Data and instruction word width
`define XLEN 32

////////////////////
// Integer register file

// x0 is counted but never stored
`define NUM_REGS 32

// Wide enough to name every register
`define REG_ADDR_W 5

`endif

/* verilog/riscv_types_pkg.sv */
`default_nettype none

package riscv_types_pkg;

    // Only the two integer ALU groups are recognised
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011
    } opcode_t;

    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } alu_funct3_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        alu_funct3_t funct3;
        logic [4:0] rd;
        opcode_t opcode;
    } r_type_t;

    // Shift immediates keep the SRA select in imm bit 10
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0] rs1;
        alu_funct3_t funct3;
        logic [4:0] rd;
        opcode_t opcode;
    } i_type_t;

    // Same 32-bit word, two field layouts
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instruction_t;

endpackage

`default_nettype wire

/* verilog/core_types_pkg.sv */
`default_nettype none

`include "core_config.svh"

package core_types_pkg;

    import riscv_types_pkg::*;

    // Decoded operation handed from issue to the ALU
    typedef struct packed {
        logic valid;
        alu_funct3_t funct3;
        logic alt;
        logic use_imm;
        logic [`XLEN-1:0] imm;
        logic [`REG_ADDR_W-1:0] rd;
        logic writes_rd;
    } issue_packet_t;

    typedef struct packed {
        logic valid;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0] data;
    } wb_packet_t;

    typedef struct packed {
        logic [`XLEN-1:0] rs1_data;
        logic [`XLEN-1:0] rs2_data;
    } reg_read_t;

endpackage

`default_nettype wire

/* verilog/decode_issue.sv */
`default_nettype none
`timescale 1ns/1ps

`include "core_config.svh"

module decode_issue
    import riscv_types_pkg::*;
    import core_types_pkg::*;
(
    input wire logic clk,
    input wire logic rst,
    input wire logic instr_valid,
    input wire instruction_t instr,
    output logic [1:0][`REG_ADDR_W-1:0] rs_addr,
    output issue_packet_t issue,
    output logic instruction_issued,
    output instruction_t issued_instruction
);

    logic is_op;
    logic is_op_imm;
    issue_packet_t issue_next;

    ////////////////////
    // Decode

    assign is_op = (instr.r.opcode == OP);
    assign is_op_imm = (instr.i.opcode == OP_IMM);

    // Register file addresses come straight off the incoming word
    assign rs_addr[0] = instr.r.rs1;
    assign rs_addr[1] = instr.r.rs2;

    always_comb begin
        issue_next.valid = instr_valid && (is_op || is_op_imm);
        issue_next.funct3 = instr.r.funct3;
        // Bit 30 picks SUB/SRA; among immediates only SRAI uses it
        issue_next.alt = instr.r.funct7[5] && (is_op || instr.i.funct3 == F3_SRL_SRA);
        issue_next.use_imm = is_op_imm;
        issue_next.imm = {{(`XLEN-12){instr.i.imm[11]}}, instr.i.imm};
        issue_next.rd = instr.r.rd;
        // x0 destinations still issue but never write back
        issue_next.writes_rd = (instr.r.rd != '0);
    end

    ////////////////////
    // Issue register

    always_ff @(posedge clk) begin
        issue <= issue_next;
        issued_instruction <= instr;
        if (rst)
            issue.valid <= 1'b0;
    end

    // Trace strobe mirrors the packet valid
    assign instruction_issued = issue.valid;

    ////////////////////
    // Assertions

    issue_needs_valid_word : assert property (
        @(posedge clk) disable iff (rst)
        instruction_issued |-> $past(instr_valid)
    ) else $error("Issue without a valid input word");

endmodule

`default_nettype wire

/* verilog/register_file.sv */
`default_nettype none
`timescale 1ns/1ps

`include "core_config.svh"

module register_file
    import core_types_pkg::*;
(
    input wire logic clk,
    input wire logic rst,
    input wire logic [1:0][`REG_ADDR_W-1:0] rs_addr,
    input wire wb_packet_t wb,
    output reg_read_t operands
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:`NUM_REGS-1];
    logic [1:0][`XLEN-1:0] read_next;
    logic [1:0][`XLEN-1:0] read_q;
    logic [1:0][`REG_ADDR_W-1:0] rs_addr_q;
    logic [1:0][`XLEN-1:0] read_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wb.valid) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Array read, with the write landing on this edge passed through
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (wb.valid && wb.rd == rs_addr[i])
                read_next[i] = wb.data;
            else if (rs_addr[i] == '0)
                read_next[i] = '0;
            else
                read_next[i] = regs[rs_addr[i]];
        end
    end

    always_ff @(posedge clk) begin
        read_q <= read_next;
        rs_addr_q <= rs_addr;
    end

    // Result of the op just ahead arrives one cycle late, bypass it here
    always_comb begin
        for (int i = 0; i < 2; i++)
            read_data[i] = (wb.valid && wb.rd == rs_addr_q[i]) ? wb.data : read_q[i];
    end

    assign operands.rs1_data = read_data[0];
    assign operands.rs2_data = read_data[1];

    no_x0_write : assert property (
        @(posedge clk) disable iff (rst)
        wb.valid |-> (wb.rd != '0)
    ) else $error("Writeback targets x0");

endmodule

`default_nettype wire

/* verilog/alu_unit.sv */
`default_nettype none
`timescale 1ns/1ps

`include "core_config.svh"

module alu_unit
    import riscv_types_pkg::*;
    import core_types_pkg::*;
(
    input wire logic clk,
    input wire logic rst,
    input wire issue_packet_t issue,
    input wire reg_read_t operands,
    output wb_packet_t wb
);

    logic [`XLEN-1:0] src_a;
    logic [`XLEN-1:0] src_b;
    logic [4:0] shamt;
    logic signed [`XLEN-1:0] sra_result;
    logic [`XLEN-1:0] result;

    ////////////////////
    // Operands

    assign src_a = operands.rs1_data;
    assign src_b = issue.use_imm ? issue.imm : operands.rs2_data;

    // RV32 shifts only look at the low five bits
    assign shamt = src_b[4:0];

    // Kept apart so the arithmetic shift stays signed
    assign sra_result = $signed(src_a) >>> shamt;

    ////////////////////
    // Operation select

    always_comb begin
        case (issue.funct3)
            F3_ADD_SUB:
                result = issue.alt ? (src_a - src_b) : (src_a + src_b);
            F3_SLL:
                result = src_a << shamt;
            F3_SLT:
                result = {{(`XLEN-1){1'b0}}, ($signed(src_a) < $signed(src_b))};
            F3_SLTU:
                result = {{(`XLEN-1){1'b0}}, (src_a < src_b)};
            F3_XOR:
                result = src_a ^ src_b;
            F3_SRL_SRA:
                result = issue.alt ? sra_result : (src_a >> shamt);
            F3_OR:
                result = src_a | src_b;
            F3_AND:
                result = src_a & src_b;
            default:
                result = '0;
        endcase
    end

    ////////////////////
    // Writeback register

    always_ff @(posedge clk) begin
        wb.rd <= issue.rd;
        wb.data <= result;
        if (rst)
            wb.valid <= 1'b0;
        else
            wb.valid <= issue.valid && issue.writes_rd;
    end

    // Only real destinations reach writeback
    wb_nonzero_rd : assert property (
        @(posedge clk) disable iff (rst)
        wb.valid |-> (wb.rd != '0)
    ) else $error("Writeback to x0");

endmodule

`default_nettype wire

/* verilog/alu_core.sv */
`default_nettype none
`timescale 1ns/1ps

`include "core_config.svh"

module alu_core
    import riscv_types_pkg::*;
    import core_types_pkg::*;
(
    input wire logic clk,
    input wire logic rst,
    input wire logic instr_valid,
    input wire instruction_t instr,
    output logic instruction_issued,
    output instruction_t issued_instruction,
    output logic wb_valid,
    output logic [`REG_ADDR_W-1:0] wb_rd,
    output logic [`XLEN-1:0] wb_data
);

    logic [1:0][`REG_ADDR_W-1:0] rs_addr;
    issue_packet_t issue;
    reg_read_t operands;
    wb_packet_t wb;

    ////////////////////
    // Decode and issue
    decode_issue decode_issue_block (
        .clk                (clk),
        .rst                (rst),
        .instr_valid        (instr_valid),
        .instr              (instr),
        .rs_addr            (rs_addr),
        .issue              (issue),
        .instruction_issued (instruction_issued),
        .issued_instruction (issued_instruction)
    );

    // Integer registers beside the ALU
    register_file register_file_block (
        .clk      (clk),
        .rst      (rst),
        .rs_addr  (rs_addr),
        .wb       (wb),
        .operands (operands)
    );

    alu_unit alu_unit_block (
        .clk      (clk),
        .rst      (rst),
        .issue    (issue),
        .operands (operands),
        .wb       (wb)
    );

    assign wb_valid = wb.valid;
    assign wb_rd = wb.rd;
    assign wb_data = wb.data;

endmodule

`default_nettype wire

/* testbench/tb_alu_core.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_alu_core;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_VECTORS = 64;
    // ADDI x31, x0, 1 held on the bus while valid is low
    localparam logic [31:0] IDLE_WORD = 32'h00100f93;

    logic clk;
    logic rst;
    logic instr_valid;
    logic [31:0] instr;
    logic instruction_issued;
    logic [31:0] issued_instruction;
    logic wb_valid;
    logic [4:0] wb_rd;
    logic [31:0] wb_data;

    // Four words per row: instruction, kind, rd, data
    logic [31:0] golden [0:4*MAX_VECTORS-1];
    int num_vectors;
    logic vectors_ready;
    logic [15:0] lfsr_state;
    int cycle_count = 0;
    logic [31:0] exp_issue [$];
    int exp_issue_cycle [$];
    logic [31:0] exp_wb_rd [$];
    logic [31:0] exp_wb_data [$];
    int exp_wb_cycle [$];

    alu_core alu_core_inst (
        .clk                (clk),
        .rst                (rst),
        .instr_valid        (instr_valid),
        .instr              (instr),
        .instruction_issued (instruction_issued),
        .issued_instruction (issued_instruction),
        .wb_valid           (wb_valid),
        .wb_rd              (wb_rd),
        .wb_data            (wb_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Rising edges seen so far
    always @(posedge clk)
        cycle_count <= cycle_count + 1;

    ////////////////////
    // Helpers

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    // Two LFSR bits give 0 to 3 idle cycles
    function automatic int pick_gap();
        logic [1:0] bits;
        for (int b = 0; b < 2; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits[b] = lfsr_state[0];
        end
        return int'(bits);
    endfunction

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: got %h, expected %h", name, actual, expected);
            abort_run();
        end
    endtask

    ////////////////////
    // Output monitor

    // Outputs are registered, so mid-cycle values are settled
    always @(negedge clk) begin
        if (!rst && instruction_issued) begin
            if (exp_issue.size() == 0) begin
                $display("Issue strobe with no instruction pending, word %h", issued_instruction);
                abort_run();
            end else begin
                compare_value("issued_instruction", issued_instruction, exp_issue.pop_front());
                compare_value("issue_cycle", cycle_count, exp_issue_cycle.pop_front());
            end
        end
        if (!rst && wb_valid) begin
            if (exp_wb_rd.size() == 0) begin
                $display("Writeback to x%0d with no result pending", wb_rd);
                abort_run();
            end else begin
                compare_value("wb_rd", {27'b0, wb_rd}, exp_wb_rd.pop_front());
                compare_value("wb_data", wb_data, exp_wb_data.pop_front());
                compare_value("wb_cycle", cycle_count, exp_wb_cycle.pop_front());
            end
        end
    end

    ////////////////////
    // Stimulus

    initial begin
        int gap;
        int base;
        clk = 1'b0;
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = IDLE_WORD;
        lfsr_state = 16'd47763;
        num_vectors = 0;
        vectors_ready = 1'b0;
        $readmemh("testbench/golden_vectors.txt", golden);
        while (num_vectors < MAX_VECTORS && golden[4*num_vectors+1] != 32'hff)
            num_vectors++;
        if (num_vectors == MAX_VECTORS) begin
            $display("Golden vector file has no end marker row");
            abort_run();
        end
        vectors_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        compare_value("instruction_issued", {31'b0, instruction_issued}, 32'h0);
        compare_value("wb_valid", {31'b0, wb_valid}, 32'h0);
        for (int v = 0; v < num_vectors; v++) begin
            base = 4 * v;
            gap = pick_gap();
            repeat (gap) begin
                @(negedge clk);
                instr_valid = 1'b0;
                instr = IDLE_WORD;
            end
            @(negedge clk);
            instr_valid = 1'b1;
            instr = golden[base];
            // Kind bit 0 means issued, bit 1 means written back
            // Issue lands one cycle after the drive and writeback one cycle later
            if (golden[base+1][0]) begin
                exp_issue.push_back(golden[base]);
                exp_issue_cycle.push_back(cycle_count + 1);
            end
            if (golden[base+1][1]) begin
                exp_wb_rd.push_back(golden[base+2]);
                exp_wb_data.push_back(golden[base+3]);
                exp_wb_cycle.push_back(cycle_count + 2);
            end
        end
        @(negedge clk);
        instr_valid = 1'b0;
        instr = IDLE_WORD;
        while (exp_issue.size() != 0 || exp_wb_rd.size() != 0)
            @(negedge clk);
        // A few quiet cycles to catch stray strobes
        repeat (3) @(negedge clk);
        $display("Test completed successfully");
        $finish;
    end

    // Watchdog
    initial begin
        wait (vectors_ready === 1'b1);
        repeat (num_vectors * 6 + RESET_CYCLES) @(posedge clk);
        $display("Timeout, the run did not finish in %0d cycles", num_vectors * 6 + RESET_CYCLES);
        abort_run();
    end

endmodule

`default_nettype wire

/* testbench/golden_vectors.txt */
// Columns: instruction word, kind (1 issue only, 3 issue and writeback, 0 dropped, ff end),
// expected rd, expected writeback data
009382b3 03 05 00000000 // add  x5, x7, x9 (never written)
06400093 03 01 00000064 // addi x1, x0, 100
ff900113 03 02 fffffff9 // addi x2, x0, -7
002081b3 03 03 0000005d // add  x3, x1, x2
40110233 03 04 ffffff95 // sub  x4, x2, x1
001122b3 03 05 00000001 // slt  x5, x2, x1
00113333 03 06 00000000 // sltu x6, x2, x1
40115393 03 07 fffffffc // srai x7, x2, 1
00315433 03 08 00000007 // srl  x8, x2, x3
01919513 03 0a ba000000 // slli x10, x3, 25
408554b3 03 09 ff740000 // sra  x9, x10, x8
01c55593 03 0b 0000000b // srli x11, x10, 28
fff0c613 03 0c ffffff9b // xori x12, x1, -1
ffa12693 03 0d 00000001 // slti x13, x2, -6
fff0b713 03 0e 00000001 // sltiu x14, x1, -1
7f05e793 03 0f 000007fb // ori  x15, x11, 0x7f0
ff067813 03 10 ffffff90 // andi x16, x12, -16
00012083 00 00 00000000 // lw   x1, 0(x2) is dropped
00208033 01 00 00000000 // add  x0, x1, x2
00f0e8b3 03 11 000007ff // or   x17, x1, x15
0098c933 03 12 ff7407ff // xor  x18, x17, x9
00d899b3 03 13 00000ffe // sll  x19, x17, x13
00c97a33 03 14 ff74079b // and  x20, x18, x12
00000000 ff 00 00000000

/* list.f */
+incdir+verilog
verilog/riscv_types_pkg.sv
verilog/core_types_pkg.sv
verilog/decode_issue.sv
verilog/register_file.sv
verilog/alu_unit.sv
verilog/alu_core.sv
testbench/tb_alu_core.sv

/* Makefile */
TOP := tb_alu_core
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f list.f

sim:
	verilator --binary --assert --top-module $(TOP) -f list.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
